// ==== logic/mem_pkg.sv ====
// Shared definitions for the memory tile
// Sizes, address field offsets, opcode and owner enums,
// and the request structs of the narrow, wide and memory paths
package mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned WORD_WIDTH         = 32;
  localparam int unsigned WORD_BYTES         = WORD_WIDTH / 8;
  localparam int unsigned NUM_BANKS_PER_WORD = 4;
  localparam int unsigned LINE_WIDTH         = WORD_WIDTH * NUM_BANKS_PER_WORD;
  localparam int unsigned LINE_BYTES         = LINE_WIDTH / 8;
  localparam int unsigned SRAM_NUM_WORDS     = 64;
  localparam int unsigned NUM_BANK_ROWS      = 2;
  // 2 KiB of byte addresses
  localparam int unsigned ADDR_WIDTH         = 11;

  // Byte address fields
  localparam int unsigned BANK_SEL_OFFSET = 2;
  localparam int unsigned BANK_SEL_WIDTH  = 2;
  localparam int unsigned SRAM_ADDR_OFFSET = 4;
  localparam int unsigned SRAM_ADDR_WIDTH  = 6;
  localparam int unsigned ROW_SEL_OFFSET  = 10;
  localparam int unsigned ROW_SEL_WIDTH   = 1;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_LOAD,
    OP_STORE,
    OP_AMO_ADD,
    OP_AMO_SWAP
  } narrow_op_e;

  typedef enum logic {
    OWNER_NARROW,
    OWNER_WIDE
  } owner_e;

  typedef struct packed {
    narrow_op_e              op;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [WORD_WIDTH-1:0]   wdata;
    logic [WORD_BYTES-1:0]   be;
  } narrow_req_t;

  typedef struct packed {
    logic                    we;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [LINE_WIDTH-1:0]   wdata;
    logic [LINE_BYTES-1:0]   be;
  } wide_req_t;

  // Arbitrated request to the bank array
  typedef struct packed {
    logic                    we;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [LINE_WIDTH-1:0]   wdata;
    logic [LINE_BYTES-1:0]   be;
  } mem_req_t;

endpackage

// ==== logic/sram_macro.sv ====
`timescale 1ns/100ps
// Single-port SRAM macro
// Byte-enable writes, registered read with one cycle latency
module sram_macro
  import mem_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [SRAM_ADDR_WIDTH-1:0] addr_i,
  input  logic [WORD_WIDTH-1:0]      wdata_i,
  input  logic [WORD_BYTES-1:0]      be_i,
  output logic [WORD_WIDTH-1:0]      rdata_o
);

  logic [WORD_WIDTH-1:0] mem [SRAM_NUM_WORDS];
  logic [WORD_WIDTH-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < WORD_BYTES; b++) begin
          if (be_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== logic/sram_bank_array.sv ====
`timescale 1ns/100ps
// Banked SRAM behind the arbiter
// Splits a line over the banks of one row and selects the row from the address,
// read data is assembled from the row registered at the read
module sram_bank_array
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  mem_req_t              mem_req_i,
  output logic [LINE_WIDTH-1:0] rdata_o
);

  logic [SRAM_ADDR_WIDTH-1:0] sram_addr;
  logic [ROW_SEL_WIDTH-1:0]   row_sel;
  logic [ROW_SEL_WIDTH-1:0]   row_sel_q;

  logic [NUM_BANK_ROWS-1:0][NUM_BANKS_PER_WORD-1:0][WORD_WIDTH-1:0] bank_rdata;
  logic [NUM_BANKS_PER_WORD-1:0][WORD_WIDTH-1:0]                    bank_wdata;
  logic [NUM_BANKS_PER_WORD-1:0][WORD_BYTES-1:0]                    bank_be;

  // Byte offset and bank bits are not needed, a line spans all banks
  assign sram_addr = mem_req_i.addr[SRAM_ADDR_OFFSET +: SRAM_ADDR_WIDTH];
  assign row_sel   = mem_req_i.addr[ROW_SEL_OFFSET +: ROW_SEL_WIDTH];

  // Remember the row of a read so the data next cycle comes from it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      row_sel_q <= '0;
    end else if (req_i && !mem_req_i.we) begin
      row_sel_q <= row_sel;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Banks and rows
  ////////////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < NUM_BANKS_PER_WORD; b++) begin : gen_banks
    assign bank_wdata[b] = mem_req_i.wdata[b*WORD_WIDTH +: WORD_WIDTH];
    assign bank_be[b]    = mem_req_i.be[b*WORD_BYTES +: WORD_BYTES];

    for (genvar r = 0; r < NUM_BANK_ROWS; r++) begin : gen_rows
      sram_macro sram_macro_inst (
        .clk_i   (clk_i),
        .req_i   (req_i && (row_sel == ROW_SEL_WIDTH'(r))),
        .we_i    (mem_req_i.we),
        .addr_i  (sram_addr),
        .wdata_i (bank_wdata[b]),
        .be_i    (bank_be[b]),
        .rdata_o (bank_rdata[r][b])
      );
    end

    assign rdata_o[b*WORD_WIDTH +: WORD_WIDTH] = bank_rdata[row_sel_q][b];
  end

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/100ps
// Two-way round-robin arbiter in front of the bank array
// Lock from the atomic unit holds the grant on the narrow side,
// a registered owner steers the response one cycle after the grant
module mem_arbiter
  import mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  // Narrow requester, from the atomic unit
  input  logic      narrow_valid_i,
  input  mem_req_t  narrow_req_i,
  input  logic      narrow_lock_i,
  output logic      narrow_gnt_o,
  output logic      narrow_rsp_valid_o,
  // Wide requester
  input  logic      wide_valid_i,
  input  wide_req_t wide_req_i,
  output logic      wide_gnt_o,
  output logic      wide_rsp_valid_o,
  // To the bank array
  output logic      mem_req_valid_o,
  output mem_req_t  mem_req_o
);

  owner_e   prio_q;
  owner_e   owner_q;
  logic     rsp_pending_q;
  mem_req_t wide_mem_req;

  always_comb begin
    narrow_gnt_o = 1'b0;
    wide_gnt_o   = 1'b0;
    if (narrow_lock_i) begin
      // Atomic in progress, the wide side waits
      narrow_gnt_o = narrow_valid_i;
    end else if (narrow_valid_i && wide_valid_i) begin
      narrow_gnt_o = (prio_q == OWNER_NARROW);
      wide_gnt_o   = (prio_q == OWNER_WIDE);
    end else begin
      narrow_gnt_o = narrow_valid_i;
      wide_gnt_o   = wide_valid_i;
    end
  end

  assign wide_mem_req.we    = wide_req_i.we;
  assign wide_mem_req.addr  = wide_req_i.addr;
  assign wide_mem_req.wdata = wide_req_i.wdata;
  assign wide_mem_req.be    = wide_req_i.be;

  assign mem_req_valid_o = narrow_gnt_o || wide_gnt_o;
  assign mem_req_o       = narrow_gnt_o ? narrow_req_i : wide_mem_req;

  // The side just served gets the lower priority
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q        <= OWNER_NARROW;
      owner_q       <= OWNER_NARROW;
      rsp_pending_q <= 1'b0;
    end else begin
      rsp_pending_q <= mem_req_valid_o;
      if (narrow_gnt_o) begin
        owner_q <= OWNER_NARROW;
        prio_q  <= OWNER_WIDE;
      end else if (wide_gnt_o) begin
        owner_q <= OWNER_WIDE;
        prio_q  <= OWNER_NARROW;
      end
    end
  end

  assign narrow_rsp_valid_o = rsp_pending_q && (owner_q == OWNER_NARROW);
  assign wide_rsp_valid_o   = rsp_pending_q && (owner_q == OWNER_WIDE);

endmodule

// ==== logic/atomic_unit.sv ====
`timescale 1ns/100ps
// Narrow port front end
// Places words in their lane of the line and extracts returned words,
// resolves atomic add and swap as a locked read followed by a write
module atomic_unit
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Narrow port
  input  logic                  req_valid_i,
  input  narrow_req_t           req_i,
  output logic                  gnt_o,
  output logic                  rsp_valid_o,
  output logic [WORD_WIDTH-1:0] rdata_o,
  // To the arbiter
  output logic                  mem_valid_o,
  output mem_req_t              mem_req_o,
  output logic                  mem_lock_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rsp_valid_i,
  input  logic [LINE_WIDTH-1:0] mem_rdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    AMO_READ_WAIT,
    AMO_WRITE
  } amo_state_e;

  // Bookkeeping of the access granted last cycle
  typedef struct packed {
    logic                      internal;
    logic [BANK_SEL_WIDTH-1:0] lane;
  } inflight_t;

  amo_state_e state_q;
  amo_state_e state_d;
  inflight_t  inflight_q;

  narrow_req_t               amo_q;
  logic [WORD_WIDTH-1:0]     old_q;
  logic [WORD_WIDTH-1:0]     rsp_word;
  logic [WORD_WIDTH-1:0]     amo_result;
  logic [BANK_SEL_WIDTH-1:0] req_lane;
  logic [BANK_SEL_WIDTH-1:0] amo_lane;
  logic                      req_is_amo;

  // Byte enables of one word moved to its lane
  function automatic logic [LINE_BYTES-1:0] lane_be(input logic [BANK_SEL_WIDTH-1:0] lane,
                                                    input logic [WORD_BYTES-1:0] be);
    logic [LINE_BYTES-1:0] line_be;
    line_be = '0;
    for (int i = 0; i < NUM_BANKS_PER_WORD; i++) begin
      if (lane == BANK_SEL_WIDTH'(i)) begin
        line_be[i*WORD_BYTES +: WORD_BYTES] = be;
      end
    end
    return line_be;
  endfunction

  assign req_lane   = req_i.addr[BANK_SEL_OFFSET +: BANK_SEL_WIDTH];
  assign amo_lane   = amo_q.addr[BANK_SEL_OFFSET +: BANK_SEL_WIDTH];
  assign req_is_amo = (req_i.op == OP_AMO_ADD) || (req_i.op == OP_AMO_SWAP);
  assign rsp_word   = mem_rdata_i[inflight_q.lane*WORD_WIDTH +: WORD_WIDTH];
  // Full word, wraps modulo 2^32
  assign amo_result = (amo_q.op == OP_AMO_ADD) ? old_q + amo_q.wdata : amo_q.wdata;

  ////////////////////////////////////////////////////////////////////////////
  // Request path and atomic FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    mem_valid_o     = 1'b0;
    mem_req_o.we    = 1'b0;
    mem_req_o.addr  = req_i.addr;
    mem_req_o.wdata = {NUM_BANKS_PER_WORD{req_i.wdata}};
    mem_req_o.be    = lane_be(req_lane, req_i.be);
    case (state_q)
      IDLE: begin
        mem_valid_o  = req_valid_i;
        mem_req_o.we = (req_i.op == OP_STORE);
        if (req_valid_i && mem_gnt_i && req_is_amo) begin
          state_d = AMO_READ_WAIT;
        end
      end
      AMO_READ_WAIT: begin
        if (mem_rsp_valid_i) begin
          state_d = AMO_WRITE;
        end
      end
      AMO_WRITE: begin
        mem_valid_o     = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = amo_q.addr;
        mem_req_o.wdata = {NUM_BANKS_PER_WORD{amo_result}};
        mem_req_o.be    = lane_be(amo_lane, '1);
        if (mem_gnt_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign mem_lock_o = (state_q != IDLE);
  assign gnt_o      = (state_q == IDLE) && mem_gnt_i;

  // Old value returns with the write grant, internal accesses stay hidden
  assign rsp_valid_o = ((state_q == AMO_WRITE) && mem_gnt_i) ||
                       (mem_rsp_valid_i && !inflight_q.internal);
  assign rdata_o     = (state_q == AMO_WRITE) ? old_q : rsp_word;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= IDLE;
      inflight_q <= '0;
    end else begin
      state_q <= state_d;
      if (mem_gnt_i) begin
        inflight_q.internal <= (state_q != IDLE) || req_is_amo;
        inflight_q.lane     <= mem_req_o.addr[BANK_SEL_OFFSET +: BANK_SEL_WIDTH];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && mem_gnt_i && req_is_amo) begin
      amo_q <= req_i;
    end
    if ((state_q == AMO_READ_WAIT) && mem_rsp_valid_i) begin
      old_q <= rsp_word;
    end
  end

endmodule

// ==== logic/mem_tile_top.sv ====
`timescale 1ns/100ps
// Memory tile top level
// Narrow port through the atomic unit, wide port direct,
// both arbitrated onto one banked SRAM
module mem_tile_top
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Narrow port
  input  logic                  narrow_req_valid_i,
  input  narrow_req_t           narrow_req_i,
  output logic                  narrow_gnt_o,
  output logic                  narrow_rsp_valid_o,
  output logic [WORD_WIDTH-1:0] narrow_rdata_o,
  // Wide port
  input  logic                  wide_req_valid_i,
  input  wide_req_t             wide_req_i,
  output logic                  wide_gnt_o,
  output logic                  wide_rsp_valid_o,
  output logic [LINE_WIDTH-1:0] wide_rdata_o
);

  logic                  amo_mem_valid;
  mem_req_t              amo_mem_req;
  logic                  amo_mem_lock;
  logic                  amo_mem_gnt;
  logic                  amo_mem_rsp_valid;
  logic                  mem_req_valid;
  mem_req_t              mem_req;
  logic [LINE_WIDTH-1:0] mem_rdata;

  atomic_unit atomic_unit_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (narrow_req_valid_i),
    .req_i           (narrow_req_i),
    .gnt_o           (narrow_gnt_o),
    .rsp_valid_o     (narrow_rsp_valid_o),
    .rdata_o         (narrow_rdata_o),
    .mem_valid_o     (amo_mem_valid),
    .mem_req_o       (amo_mem_req),
    .mem_lock_o      (amo_mem_lock),
    .mem_gnt_i       (amo_mem_gnt),
    .mem_rsp_valid_i (amo_mem_rsp_valid),
    .mem_rdata_i     (mem_rdata)
  );

  mem_arbiter mem_arbiter_inst (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .narrow_valid_i     (amo_mem_valid),
    .narrow_req_i       (amo_mem_req),
    .narrow_lock_i      (amo_mem_lock),
    .narrow_gnt_o       (amo_mem_gnt),
    .narrow_rsp_valid_o (amo_mem_rsp_valid),
    .wide_valid_i       (wide_req_valid_i),
    .wide_req_i         (wide_req_i),
    .wide_gnt_o         (wide_gnt_o),
    .wide_rsp_valid_o   (wide_rsp_valid_o),
    .mem_req_valid_o    (mem_req_valid),
    .mem_req_o          (mem_req)
  );

  sram_bank_array sram_bank_array_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (mem_req_valid),
    .mem_req_i (mem_req),
    .rdata_o   (mem_rdata)
  );

  // Read line is shared, the response valids tell who owns it
  assign wide_rdata_o = mem_rdata;

endmodule

// ==== testbench/tb_ref_model.svh ====
// Reference model of the memory tile
// Byte image of the whole tile, fill pattern and expected read data
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [7:0] ref_mem [1 << ADDR_WIDTH];

// Every address bit changes the word
function automatic logic [WORD_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
  return (32'(addr) * 32'h9e37_79b9) ^ {21'h1b5a3, addr};
endfunction

function automatic logic [LINE_WIDTH-1:0] fill_line(input logic [ADDR_WIDTH-1:0] addr);
  logic [LINE_WIDTH-1:0] line;
  for (int i = 0; i < NUM_BANKS_PER_WORD; i++) begin
    line[i*WORD_WIDTH +: WORD_WIDTH] = fill_word(addr + ADDR_WIDTH'(i * WORD_BYTES));
  end
  return line;
endfunction

// Old word of a narrow access, its update is applied at acceptance
function automatic logic [WORD_WIDTH-1:0] ref_narrow(input narrow_req_t req);
  logic [WORD_WIDTH-1:0] old_word;
  logic [WORD_WIDTH-1:0] new_word;
  for (int i = 0; i < WORD_BYTES; i++) begin
    old_word[i*8 +: 8] = ref_mem[{req.addr[ADDR_WIDTH-1:2], 2'(i)}];
  end
  new_word = old_word;
  case (req.op)
    OP_STORE: begin
      for (int i = 0; i < WORD_BYTES; i++) begin
        if (req.be[i]) new_word[i*8 +: 8] = req.wdata[i*8 +: 8];
      end
    end
    // Atomics cover the full word whatever the byte enables say
    OP_AMO_ADD:  new_word = old_word + req.wdata;
    OP_AMO_SWAP: new_word = req.wdata;
    default: ;
  endcase
  for (int i = 0; i < WORD_BYTES; i++) begin
    ref_mem[{req.addr[ADDR_WIDTH-1:2], 2'(i)}] = new_word[i*8 +: 8];
  end
  return old_word;
endfunction

// Line as it was before a wide access, writes honour the byte enables
function automatic logic [LINE_WIDTH-1:0] ref_wide(input wide_req_t req);
  logic [LINE_WIDTH-1:0] old_line;
  for (int i = 0; i < LINE_BYTES; i++) begin
    old_line[i*8 +: 8] = ref_mem[{req.addr[ADDR_WIDTH-1:4], 4'(i)}];
    if (req.we && req.be[i]) ref_mem[{req.addr[ADDR_WIDTH-1:4], 4'(i)}] = req.wdata[i*8 +: 8];
  end
  return old_line;
endfunction

`endif

// ==== testbench/tb_mem_tile.sv ====
`timescale 1ns/100ps
// Testbench of the memory tile
// Clock, reset, directed and random stimulus, compare process and timeout
module tb_mem_tile
  import mem_pkg::*;
();

  localparam int NUM_LINES  = (1 << ADDR_WIDTH) / LINE_BYTES;
  localparam int NUM_WORDS  = (1 << ADDR_WIDTH) / WORD_BYTES;
  localparam int RAND_REQS  = 2000;
  // About four times the cycles that all tests take together
  localparam int MAX_CYCLES = 20000;

  logic                  clk_i;
  logic                  reset_i;
  logic                  narrow_req_valid_i;
  narrow_req_t           narrow_req_i;
  logic                  narrow_gnt_o;
  logic                  narrow_rsp_valid_o;
  logic [WORD_WIDTH-1:0] narrow_rdata_o;
  logic                  wide_req_valid_i;
  wide_req_t             wide_req_i;
  logic                  wide_gnt_o;
  logic                  wide_rsp_valid_o;
  logic [LINE_WIDTH-1:0] wide_rdata_o;

  integer seed = 32'h5fa3_52d9;
  int     cycles = 0;
  int     errors = 0;
  int     checks = 0;
  int     err_mark = 0;
  int     narrow_acc = 0;
  int     narrow_rsp = 0;
  int     wide_acc = 0;
  int     wide_rsp = 0;
  int     narrow_acc_cycle;

  // Expected responses in acceptance order
  logic [WORD_WIDTH-1:0] narrow_exp [$];
  bit                    narrow_chk [$];
  int                    narrow_cyc [$];
  logic [LINE_WIDTH-1:0] wide_exp [$];
  bit                    wide_chk [$];

  `include "tb_ref_model.svh"

  mem_tile_top mem_tile_top_inst (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_narrow(input logic [WORD_WIDTH-1:0] exp, input bit chk, input int acc);
    checks++;
    if (chk && narrow_rdata_o !== exp) begin
      $display("[FAIL] narrow_rdata_o expected %h got %h", exp, narrow_rdata_o);
      errors++;
    end
    if (acc >= 0 && cycles != acc + 1) begin
      $display("Narrow response came %0d cycles after acceptance instead of 1", cycles - acc);
      errors++;
    end
  endtask

  task automatic check_wide(input logic [LINE_WIDTH-1:0] exp, input bit chk);
    checks++;
    if (chk && wide_rdata_o !== exp) begin
      $display("[FAIL] wide_rdata_o expected %h got %h", exp, wide_rdata_o);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////////////////////

  // Responses of a cycle are taken before its acceptances
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (narrow_rsp_valid_o) begin
        narrow_rsp++;
        if (narrow_exp.size() == 0) begin
          $display("Narrow response at cycle %0d with no request outstanding", cycles);
          errors++;
        end else begin
          check_narrow(narrow_exp.pop_front(), narrow_chk.pop_front(), narrow_cyc.pop_front());
        end
      end
      if (wide_rsp_valid_o) begin
        wide_rsp++;
        if (wide_exp.size() == 0) begin
          $display("Wide response at cycle %0d with no request outstanding", cycles);
          errors++;
        end else begin
          check_wide(wide_exp.pop_front(), wide_chk.pop_front());
        end
      end
      if (narrow_req_valid_i && narrow_gnt_o) begin
        narrow_acc++;
        narrow_exp.push_back(ref_narrow(narrow_req_i));
        narrow_chk.push_back(narrow_req_i.op != OP_STORE);
        // Atomics return after a variable delay
        narrow_cyc.push_back((narrow_req_i.op inside {OP_LOAD, OP_STORE}) ? cycles : -1);
      end
      if (wide_req_valid_i && wide_gnt_o) begin
        wide_acc++;
        wide_exp.push_back(ref_wide(wide_req_i));
        wide_chk.push_back(!wide_req_i.we);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Starts at a drive point and returns at the drive point after acceptance
  task automatic narrow_issue(input narrow_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [WORD_WIDTH-1:0] wdata,
                              input logic [WORD_BYTES-1:0] be);
    narrow_req_valid_i = 1'b1;
    narrow_req_i       = '{op: op, addr: addr, wdata: wdata, be: be};
    @(negedge clk_i);
    while (!narrow_gnt_o) @(negedge clk_i);
    narrow_acc_cycle = cycles;
    @(posedge clk_i);
    #1;
  endtask

  task automatic wide_issue(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [LINE_WIDTH-1:0] wdata,
                            input logic [LINE_BYTES-1:0] be);
    wide_req_valid_i = 1'b1;
    wide_req_i       = '{we: we, addr: addr, wdata: wdata, be: be};
    @(negedge clk_i);
    while (!wide_gnt_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic ports_idle();
    narrow_req_valid_i = 1'b0;
    wide_req_valid_i   = 1'b0;
  endtask

  task automatic check_low(input string name, input logic value);
    checks++;
    if (value !== 1'b0) begin
      $display("[FAIL] %s expected 0 got %h", name, value);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    while (narrow_exp.size() != 0 || wide_exp.size() != 0) @(negedge clk_i);
    if (narrow_acc != narrow_rsp || wide_acc != wide_rsp) begin
      $display("Response count does not match acceptance count after %s", name);
      errors++;
    end
    $display("%s: %s, %0d errors", name, (errors == err_mark) ? "ok" : "failed",
             errors - err_mark);
    err_mark = errors;
    @(posedge clk_i);
    #1;
  endtask

  // Half the accesses go to the two hot lines at 0x150 and 0x550
  function automatic logic [ADDR_WIDTH-1:0] random_addr(input int align);
    logic [ADDR_WIDTH-1:0] addr;
    addr = ADDR_WIDTH'($random(seed));
    if ($random(seed) % 2 == 0) begin
      addr[9:4] = 6'h15;
    end
    return addr >> align << align;
  endfunction

  // Drives both ports at once and issues a new request after the last one was accepted
  task automatic random_traffic(input int total);
    int issued;
    bit narrow_done;
    bit wide_done;
    issued = 0;
    while (issued < total || narrow_req_valid_i || wide_req_valid_i) begin
      @(negedge clk_i);
      narrow_done = narrow_req_valid_i && narrow_gnt_o;
      wide_done   = wide_req_valid_i && wide_gnt_o;
      @(posedge clk_i);
      #1;
      if (narrow_done || !narrow_req_valid_i) begin
        narrow_req_valid_i = 1'b0;
        if (issued < total && $random(seed) % 4 != 0) begin
          narrow_req_i = '{op: narrow_op_e'(2'($random(seed))), addr: random_addr(2),
                           wdata: $random(seed), be: WORD_BYTES'($random(seed))};
          narrow_req_valid_i = 1'b1;
          issued++;
        end
      end
      if (wide_done || !wide_req_valid_i) begin
        wide_req_valid_i = 1'b0;
        if (issued < total && $random(seed) % 4 != 0) begin
          wide_req_i = '{we: 1'($random(seed)), addr: random_addr(4),
                         wdata: {$random(seed), $random(seed), $random(seed), $random(seed)},
                         be: LINE_BYTES'($random(seed))};
          wide_req_valid_i = 1'b1;
          issued++;
        end
      end
    end
  endtask

  initial begin
    int first_cycle;
    clk_i              = 1'b0;
    reset_i            = 1'b1;
    narrow_req_valid_i = 1'b0;
    narrow_req_i       = '0;
    wide_req_valid_i   = 1'b0;
    wide_req_i         = '0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    repeat (10) begin
      @(negedge clk_i);
      check_low("narrow_gnt_o", narrow_gnt_o);
      check_low("wide_gnt_o", wide_gnt_o);
      check_low("narrow_rsp_valid_o", narrow_rsp_valid_o);
      check_low("wide_rsp_valid_o", wide_rsp_valid_o);
    end
    end_test("idle after reset");

    for (int line = 0; line < NUM_LINES; line++) begin
      wide_issue(1'b1, ADDR_WIDTH'(line * LINE_BYTES), fill_line(ADDR_WIDTH'(line * LINE_BYTES)),
                 '1);
    end
    ports_idle();
    for (int word = 0; word < NUM_WORDS; word++) begin
      narrow_issue(OP_LOAD, ADDR_WIDTH'(word * WORD_BYTES), '0, '1);
    end
    ports_idle();
    end_test("wide fill and narrow loads");

    // Stride of eight lines and a word walks all lanes and both rows
    for (int i = 0; i < 16; i++) begin
      narrow_issue(OP_STORE, ADDR_WIDTH'(i * 132), $random(seed), WORD_BYTES'(i));
    end
    ports_idle();
    // Each line that took a store is read back
    for (int i = 0; i < 16; i++) begin
      wide_issue(1'b0, ADDR_WIDTH'(i * 132 / LINE_BYTES * LINE_BYTES), '0, '0);
    end
    ports_idle();
    end_test("partial narrow stores");

    for (int i = 0; i < 8; i++) begin
      narrow_issue((i % 2 == 0) ? OP_AMO_ADD : OP_AMO_SWAP, ADDR_WIDTH'(i * 260),
                   (i == 0) ? 32'hffff_ffff : $random(seed), '0);
      narrow_issue(OP_LOAD, ADDR_WIDTH'(i * 260), '0, '1);
    end
    ports_idle();
    end_test("atomic add and swap");

    random_traffic(RAND_REQS);
    end_test("random mixed traffic");

    first_cycle = 0;
    for (int i = 0; i < 8; i++) begin
      narrow_issue(OP_LOAD, ADDR_WIDTH'(1024 + i * WORD_BYTES), '0, '1);
      if (i == 0) first_cycle = narrow_acc_cycle;
    end
    ports_idle();
    checks++;
    if (narrow_acc_cycle - first_cycle != 7) begin
      $display("Back-to-back loads were not accepted in consecutive cycles");
      errors++;
    end
    end_test("back-to-back narrow loads");

    $display("Checks %0d, errors %0d, narrow %0d/%0d, wide %0d/%0d accepted/answered",
             checks, errors, narrow_acc, narrow_rsp, wide_acc, wide_rsp);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+testbench
logic/mem_pkg.sv
logic/sram_macro.sv
logic/sram_bank_array.sv
logic/mem_arbiter.sv
logic/atomic_unit.sv
logic/mem_tile_top.sv
testbench/tb_mem_tile.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory tile testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f flist.f --top-module tb_mem_tile -o tb_mem_tile

result=$(./obj_dir/tb_mem_tile)
echo "$result"
# The run counts as passed only if the pass line was printed
echo "$result" | grep -qx "TEST RESULT: PASS"
